//--- riscvDatapath.f
+incdir+source
source/riscvIsaPkg.sv
source/datapathCtrlPkg.sv
source/ctrlIf.sv
source/registerFile.sv
source/immGen.sv
source/decoder.sv
source/controlUnit.sv
source/alu.sv
source/riscvDatapath.sv
tb/riscvDatapath_sva.sv
tb/riscvDatapathTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f riscvDatapath.f \
    --top-module riscvDatapathTb -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/VriscvDatapathTb > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }

//--- source/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_config.svh"

module alu (
    input  logic [`XLEN-1:0] inst,
    input  logic [`XLEN-1:0] rdata1,
    input  logic [`XLEN-1:0] rdata2,
    input  logic [`XLEN-1:0] imm32,
    ctrlIf.exec              ctrl,
    output logic [`XLEN-1:0] aluResult,
    output logic             branchTaken
);
    import riscvIsaPkg::*;
    import datapathCtrlPkg::*;

    logic [`XLEN-1:0]         opB;
    logic [`XLEN-1:0]         rawResult;
    logic [$clog2(`XLEN)-1:0] shamt;
    logic [2:0]               funct3;
    logic                     condMet;

    // Operand B mux
    assign opB    = ctrl.aluSrc ? imm32 : rdata2;
    assign shamt  = opB[$clog2(`XLEN)-1:0];
    assign funct3 = inst[14:12];

    // ------------------------------------------------------------
    // Arithmetic and logic
    // ------------------------------------------------------------
    always_comb begin
        case (ctrl.aluOp)
            aluSub:  rawResult = rdata1 - opB;
            aluSll:  rawResult = rdata1 << shamt;
            aluSlt:  rawResult = ($signed(rdata1) < $signed(opB)) ? `XLEN'd1 : '0;
            aluSltu: rawResult = (rdata1 < opB) ? `XLEN'd1 : '0;
            aluXor:  rawResult = rdata1 ^ opB;
            aluSrl:  rawResult = rdata1 >> shamt;
            aluSra:  rawResult = $signed(rdata1) >>> shamt;
            aluOr:   rawResult = rdata1 | opB;
            aluAnd:  rawResult = rdata1 & opB;
            default: rawResult = rdata1 + opB;
        endcase
    end

    // Jump target is halfword aligned
    assign aluResult = ctrl.isJump ? {rawResult[`XLEN-1:1], 1'b0} : rawResult;

    // ------------------------------------------------------------
    // Branch compare on the two register reads
    // ------------------------------------------------------------
    always_comb begin
        case (funct3)
            f3Beq:   condMet = (rdata1 == rdata2);
            f3Bne:   condMet = (rdata1 != rdata2);
            f3Blt:   condMet = ($signed(rdata1) < $signed(rdata2));
            f3Bge:   condMet = ($signed(rdata1) >= $signed(rdata2));
            f3Bltu:  condMet = (rdata1 < rdata2);
            f3Bgeu:  condMet = (rdata1 >= rdata2);
            default: condMet = 1'b0;
        endcase
    end

    assign branchTaken = ctrl.isBranch && condMet;

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_config.svh"

module controlUnit (
    input  logic [`XLEN-1:0] inst,
    ctrlIf.ctrl              ctrl,
    output logic             ecallValid
);
    import riscvIsaPkg::*;
    import datapathCtrlPkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    aluOpT      functOp;

    assign opcode   = opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    // Selects SUB and SRA/SRAI
    assign funct7b5 = inst[30];

    // ------------------------------------------------------------
    // Integer op from funct3 and funct7
    // ------------------------------------------------------------
    always_comb begin
        case (funct3)
            // Immediate form has no subtract
            f3AddSub: functOp = ((opcode == opcOp) && funct7b5) ? aluSub : aluAdd;
            f3Sll:    functOp = aluSll;
            f3Slt:    functOp = aluSlt;
            f3Sltu:   functOp = aluSltu;
            f3Xor:    functOp = aluXor;
            f3SrlSra: functOp = funct7b5 ? aluSra : aluSrl;
            f3Or:     functOp = aluOr;
            default:  functOp = aluAnd;
        endcase
    end

    // ------------------------------------------------------------
    // Main decode
    // ------------------------------------------------------------
    always_comb begin
        // Safe defaults, no write and no strobe
        ctrl.regWrite = 1'b0;
        ctrl.wbSel    = wbAlu;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.aluOp    = aluAdd;
        ctrl.isBranch = 1'b0;
        ctrl.isJump   = 1'b0;
        case (opcode)
            opcLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = wbImm;
            end
            opcAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = wbPcImm;
            end
            opcJal, opcJalr: begin
                // ALU forms the JALR target
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = wbPc4;
                ctrl.aluSrc   = 1'b1;
                ctrl.isJump   = 1'b1;
            end
            opcBranch: begin
                ctrl.aluOp    = aluSub;
                ctrl.isBranch = 1'b1;
            end
            opcLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = wbMem;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opcStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opcOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = functOp;
            end
            opcOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = functOp;
            end
            // SYSTEM and unknown opcodes keep the defaults
            default: ;
        endcase
    end

    // ECALL has an all-zero immediate, EBREAK does not
    assign ecallValid = (opcode == opcSystem) && (inst[31:20] == 12'd0);

endmodule

`default_nettype wire

//--- source/ctrlIf.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrlIf;
    import datapathCtrlPkg::*;

    // Writeback side
    logic  regWrite;
    wbSelT wbSel;

    // Data memory strobes
    logic  memRead;
    logic  memWrite;

    // Execute side
    logic  aluSrc;
    aluOpT aluOp;
    logic  isBranch;
    logic  isJump;

    modport ctrl (output regWrite, wbSel, memRead, memWrite, aluSrc, aluOp, isBranch, isJump);
    modport wb   (input regWrite, wbSel);
    modport exec (input aluSrc, aluOp, isBranch, isJump);

endinterface

`default_nettype wire

//--- source/datapathCtrlPkg.sv
`default_nettype none

package datapathCtrlPkg;

    // ------------------------------------------------------------
    // ALU operation select
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOpT;

    // ------------------------------------------------------------
    // Writeback source for rd
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        // OP, OP-IMM
        wbAlu   = 3'd0,
        // Loads
        wbMem   = 3'd1,
        // Link address of JAL and JALR
        wbPc4   = 3'd2,
        // LUI
        wbImm   = 3'd3,
        // AUIPC
        wbPcImm = 3'd4
    } wbSelT;

endpackage

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_config.svh"

module decoder (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] inst,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] aluResult,
    input  logic [`XLEN-1:0] memReadData,
    ctrlIf.wb                ctrl,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2,
    output logic [`XLEN-1:0] imm32,
    output logic [`XLEN-1:0] ecallCode,
    output logic [`XLEN-1:0] ecallA0
);
    import datapathCtrlPkg::*;

    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       pc4;
    logic [`XLEN-1:0]       wdata;

    // Register fields sit at fixed positions in every format
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // Link address
    assign pc4 = pc + `XLEN'd4;

    // ------------------------------------------------------------
    // Writeback mux
    // ------------------------------------------------------------
    always_comb begin
        case (ctrl.wbSel)
            wbPc4:   wdata = pc4;
            wbImm:   wdata = imm32;
            wbPcImm: wdata = pc + imm32;
            wbMem:   wdata = memReadData;
            default: wdata = aluResult;
        endcase
    end

    registerFile regFile_i (
        .clk      (clk),
        .reset    (reset),
        .raddr1   (rs1),
        .raddr2   (rs2),
        .waddr    (rd),
        .wdata    (wdata),
        .regWrite (ctrl.regWrite),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .a7Data   (ecallCode),
        .a0Data   (ecallA0)
    );

    immGen immGen_i (
        .inst  (inst),
        .imm32 (imm32)
    );

endmodule

`default_nettype wire

//--- source/immGen.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_config.svh"

module immGen (
    input  logic [`XLEN-1:0] inst,
    output logic [`XLEN-1:0] imm32
);
    import riscvIsaPkg::*;

    opcodeT opcode;
    logic   signBit;

    assign opcode  = opcodeT'(inst[6:0]);
    // Every format keeps its sign in bit 31
    assign signBit = inst[31];

    always_comb begin
        case (opcode)
            // I-type
            opcOpImm, opcLoad, opcJalr, opcSystem: begin
                imm32 = {{(`XLEN-12){signBit}}, inst[31:20]};
            end
            // S-type, split field
            opcStore: begin
                imm32 = {{(`XLEN-12){signBit}}, inst[31:25], inst[11:7]};
            end
            // B-type, halfword offset
            opcBranch: begin
                imm32 = {{(`XLEN-12){signBit}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            // U-type, upper 20 bits
            opcLui, opcAuipc: begin
                imm32 = {{(`XLEN-32){signBit}}, inst[31:12], 12'b0};
            end
            // J-type
            opcJal: begin
                imm32 = {{(`XLEN-20){signBit}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            // R-type and unknown opcodes carry no immediate
            default: imm32 = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_config.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic                   regWrite,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    output logic [`XLEN-1:0]       a7Data,
    output logic [`XLEN-1:0]       a0Data
);
    import riscvIsaPkg::*;

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (waddr != '0)) begin
            // x0 never takes a write
            regs[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------
    // Read ports, combinational
    // ------------------------------------------------------------
    // x0 keeps its reset value of zero
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // Ecall taps, service code and first argument
    assign a7Data = regs[regA7];
    assign a0Data = regs[regA0];

endmodule

`default_nettype wire

//--- source/riscvDatapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_config.svh"

module riscvDatapath (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] inst,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] memReadData,
    output logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] storeData,
    output logic             memRead,
    output logic             memWrite,
    output logic             branchTaken,
    output logic             ecallValid,
    output logic [`XLEN-1:0] ecallCode,
    output logic [`XLEN-1:0] ecallA0
);

    // Control levels from decode to writeback and execute
    ctrlIf ctrlBus ();

    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] imm32;

    // ------------------------------------------------------------
    // Decode, register file and writeback
    // ------------------------------------------------------------
    decoder decoder_i (
        .clk         (clk),
        .reset       (reset),
        .inst        (inst),
        .pc          (pc),
        .aluResult   (aluResult),
        .memReadData (memReadData),
        .ctrl        (ctrlBus.wb),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .imm32       (imm32),
        .ecallCode   (ecallCode),
        .ecallA0     (ecallA0)
    );

    controlUnit controlUnit_i (
        .inst       (inst),
        .ctrl       (ctrlBus.ctrl),
        .ecallValid (ecallValid)
    );

    // Execute
    alu alu_i (
        .inst        (inst),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .imm32       (imm32),
        .ctrl        (ctrlBus.exec),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    // Memory side
    assign storeData = rdata2;
    assign memRead   = ctrlBus.memRead;
    assign memWrite  = ctrlBus.memWrite;

endmodule

`default_nettype wire

//--- source/riscvIsaPkg.sv
`default_nettype none

`include "riscv_config.svh"

package riscvIsaPkg;

    // ------------------------------------------------------------
    // Major opcodes, inst[6:0]
    // ------------------------------------------------------------
    typedef enum logic [6:0] {
        opcLui    = 7'b0110111,
        opcAuipc  = 7'b0010111,
        opcJal    = 7'b1101111,
        opcJalr   = 7'b1100111,
        opcBranch = 7'b1100011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcOpImm  = 7'b0010011,
        opcOp     = 7'b0110011,
        opcSystem = 7'b1110011
    } opcodeT;

    // Branch conditions, inst[14:12]
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // Integer ops, shared by OP and OP-IMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // ABI registers used by the ecall convention
    localparam logic [`REG_ADDR_W-1:0] regA0 = `REG_ADDR_W'd10;
    localparam logic [`REG_ADDR_W-1:0] regA7 = `REG_ADDR_W'd17;

endpackage

`default_nettype wire

//--- source/riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// ------------------------------------------------------------
// Datapath sizing
// ------------------------------------------------------------

// Data and address width of the core
`define XLEN 32

// Architectural integer registers
`define REG_COUNT 32

// Bits needed to name one register
`define REG_ADDR_W 5

`endif

//--- tb/riscvDatapathTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_config.svh"

module riscvDatapathTb;
    import riscvIsaPkg::*;

    // One row of stimulus and expected values
    typedef struct packed {
        logic [`XLEN-1:0] inst;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] memData;
        logic [`XLEN-1:0] expAlu;
        logic [`XLEN-1:0] expStore;
        logic [`XLEN-1:0] expCode;
        logic [`XLEN-1:0] expA0;
        logic             chkAlu;
        logic             chkStore;
        logic             expMemRead;
        logic             expMemWrite;
        logic             expBranch;
        logic             expEcall;
    } rowT;

    // Strobe patterns, {memRead, memWrite, branchTaken}
    localparam logic [2:0] noStrobe = 3'b000;
    localparam logic [2:0] stRead   = 3'b100;
    localparam logic [2:0] stWrite  = 3'b010;
    localparam logic [2:0] stBranch = 3'b001;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] memReadData;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] storeData;
    logic             memRead;
    logic             memWrite;
    logic             branchTaken;
    logic             ecallValid;
    logic [`XLEN-1:0] ecallCode;
    logic [`XLEN-1:0] ecallA0;

    rowT   rows [$];
    string names [$];
    int    passCount;
    int    failCount;

    riscvDatapath riscvDatapath_i (
        .clk         (clk),
        .reset       (reset),
        .inst        (inst),
        .pc          (pc),
        .memReadData (memReadData),
        .aluResult   (aluResult),
        .storeData   (storeData),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .branchTaken (branchTaken),
        .ecallValid  (ecallValid),
        .ecallCode   (ecallCode),
        .ecallA0     (ecallA0)
    );

    // ------------------------------------------------------------
    // Clock and reset
    // ------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Two rising edges in reset, release on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    // Numerical Recipes LCG step
    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------------------------------------
    // Instruction encoders, RV32I formats
    // ------------------------------------------------------------
    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opcOp};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opcStore};
    endfunction

    // Offset bit 0 is implied
    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
    endfunction

    // PC of the next row to be added
    function automatic logic [31:0] nextPc();
        return 32'h0000_0100 + 32'(rows.size()) * 32'd4;
    endfunction

    // ------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------
    task automatic addRow(input string name, input logic [31:0] instWord,
                          input logic [31:0] memData, input logic chkAlu,
                          input logic [31:0] expAlu, input logic [2:0] strobes);
        rowT r;
        r             = '0;
        r.inst        = instWord;
        r.pc          = nextPc();
        r.memData     = memData;
        r.chkAlu      = chkAlu;
        r.expAlu      = expAlu;
        r.expMemRead  = strobes[2];
        r.expMemWrite = strobes[1];
        r.expBranch   = strobes[0];
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic markStore(input logic [31:0] expStore);
        rowT r;
        r          = rows.pop_back();
        r.chkStore = 1'b1;
        r.expStore = expStore;
        rows.push_back(r);
    endtask

    task automatic markEcall(input logic [31:0] code, input logic [31:0] a0);
        rowT r;
        r          = rows.pop_back();
        r.expEcall = 1'b1;
        r.expCode  = code;
        r.expA0    = a0;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        logic [31:0] loadVal;
        logic [31:0] auipcPc;
        logic [31:0] jalPc;
        loadVal = lcgNext(32'd75);
        // x1 = 25, x2 = -7
        addRow("addi x1", encI(12'd25, 5'd0, f3AddSub, 5'd1, opcOpImm), '0, 1, 32'd25, noStrobe);
        addRow("addi x2", encI(12'hFF9, 5'd0, f3AddSub, 5'd2, opcOpImm), '0, 1, 32'hFFFF_FFF9,
               noStrobe);
        addRow("add", encR(7'h00, 5'd2, 5'd1, f3AddSub, 5'd3), '0, 1, 32'h12, noStrobe);
        addRow("sub", encR(7'h20, 5'd2, 5'd1, f3AddSub, 5'd4), '0, 1, 32'h20, noStrobe);
        addRow("xor", encR(7'h00, 5'd2, 5'd1, f3Xor, 5'd5), '0, 1, 32'hFFFF_FFE0, noStrobe);
        addRow("slt", encR(7'h00, 5'd1, 5'd2, f3Slt, 5'd6), '0, 1, 32'd1, noStrobe);
        // x0 stays zero
        addRow("addi x0", encI(12'd5, 5'd0, f3AddSub, 5'd0, opcOpImm), '0, 1, 32'd5, noStrobe);
        addRow("read x0", encR(7'h00, 5'd0, 5'd0, f3AddSub, 5'd7), '0, 1, 32'd0, noStrobe);
        // Shifts, SRAI carries funct7 bit 5 in imm bit 10
        addRow("slli", encI(12'd4, 5'd1, f3Sll, 5'd8, opcOpImm), '0, 1, 32'h190, noStrobe);
        addRow("srli", encI(12'd4, 5'd2, f3SrlSra, 5'd9, opcOpImm), '0, 1, 32'h0FFF_FFFF,
               noStrobe);
        addRow("srai", encI(12'h401, 5'd2, f3SrlSra, 5'd10, opcOpImm), '0, 1, 32'hFFFF_FFFC,
               noStrobe);
        addRow("andi", encI(12'hFF0, 5'd1, f3And, 5'd11, opcOpImm), '0, 1, 32'h10, noStrobe);
        addRow("ori", encI(12'hF00, 5'd1, f3Or, 5'd12, opcOpImm), '0, 1, 32'hFFFF_FF19, noStrobe);
        // Upper immediates and link, exposed by the next ADDI
        addRow("lui", encU(20'h12345, 5'd13, opcLui), '0, 0, '0, noStrobe);
        addRow("lui read", encI(12'd0, 5'd13, f3AddSub, 5'd14, opcOpImm), '0, 1, 32'h1234_5000,
               noStrobe);
        auipcPc = nextPc();
        addRow("auipc", encU(20'h00001, 5'd15, opcAuipc), '0, 0, '0, noStrobe);
        addRow("auipc read", encI(12'd0, 5'd15, f3AddSub, 5'd16, opcOpImm), '0, 1,
               auipcPc + 32'h1000, noStrobe);
        jalPc = nextPc();
        addRow("jal", encJ(21'h00020, 5'd18), '0, 0, '0, noStrobe);
        addRow("jal read", encI(12'd0, 5'd18, f3AddSub, 5'd19, opcOpImm), '0, 1,
               jalPc + 32'd4, noStrobe);
        // JALR target 25 + 8 with bit 0 dropped
        addRow("jalr", encI(12'd8, 5'd1, f3AddSub, 5'd22, opcJalr), '0, 1, 32'd32, noStrobe);
        // Word load and store, funct3 010
        addRow("lw", encI(12'd8, 5'd1, 3'b010, 5'd20, opcLoad), loadVal, 1, 32'd33, stRead);
        addRow("lw read", encI(12'd0, 5'd20, f3AddSub, 5'd21, opcOpImm), '0, 1, loadVal,
               noStrobe);
        addRow("sw", encS(12'hFFC, 5'd2, 5'd1, 3'b010), '0, 1, 32'd21, stWrite);
        markStore(32'hFFFF_FFF9);
        // Branches, x1 = 25 and x2 = -7
        addRow("beq taken", encB(13'h10, 5'd1, 5'd1, f3Beq), '0, 0, '0, stBranch);
        addRow("beq not", encB(13'h10, 5'd2, 5'd1, f3Beq), '0, 0, '0, noStrobe);
        addRow("bne taken", encB(13'h10, 5'd2, 5'd1, f3Bne), '0, 0, '0, stBranch);
        addRow("bne not", encB(13'h10, 5'd1, 5'd1, f3Bne), '0, 0, '0, noStrobe);
        addRow("blt taken", encB(13'h10, 5'd1, 5'd2, f3Blt), '0, 0, '0, stBranch);
        addRow("blt not", encB(13'h10, 5'd2, 5'd1, f3Blt), '0, 0, '0, noStrobe);
        addRow("bge taken", encB(13'h10, 5'd2, 5'd1, f3Bge), '0, 0, '0, stBranch);
        addRow("bge not", encB(13'h10, 5'd1, 5'd2, f3Bge), '0, 0, '0, noStrobe);
        addRow("bltu taken", encB(13'h10, 5'd2, 5'd1, f3Bltu), '0, 0, '0, stBranch);
        addRow("bltu not", encB(13'h10, 5'd1, 5'd2, f3Bltu), '0, 0, '0, noStrobe);
        addRow("bgeu taken", encB(13'h10, 5'd1, 5'd2, f3Bgeu), '0, 0, '0, stBranch);
        addRow("bgeu not", encB(13'h10, 5'd2, 5'd1, f3Bgeu), '0, 0, '0, noStrobe);
        // Ecall with a7 = 93 and a0 = 42
        addRow("addi a7", encI(12'd93, 5'd0, f3AddSub, 5'd17, opcOpImm), '0, 1, 32'd93, noStrobe);
        addRow("addi a0", encI(12'd42, 5'd0, f3AddSub, 5'd10, opcOpImm), '0, 1, 32'd42, noStrobe);
        addRow("ecall", encI(12'd0, 5'd0, 3'b000, 5'd0, opcSystem), '0, 0, '0, noStrobe);
        markEcall(32'd93, 32'd42);
    endtask

    // ------------------------------------------------------------
    // Waits and checks
    // ------------------------------------------------------------
    task automatic waitResetRelease(output bit released);
        int cycles;
        cycles = 0;
        // Sampled on rising edges, reset only moves on falling ones
        while (reset !== 1'b0 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        released = (reset === 1'b0);
    endtask

    task automatic checkRow(input int idx, output int errs);
        rowT r;
        r    = rows[idx];
        errs = 0;
        if (r.chkAlu && aluResult !== r.expAlu) begin
            $display("MISMATCH %s aluResult got %h expected %h", names[idx], aluResult, r.expAlu);
            errs++;
        end
        if (r.chkStore && storeData !== r.expStore) begin
            $display("MISMATCH %s storeData got %h expected %h", names[idx], storeData,
                     r.expStore);
            errs++;
        end
        if (memRead !== r.expMemRead) begin
            $display("MISMATCH %s memRead got %h expected %h", names[idx], memRead, r.expMemRead);
            errs++;
        end
        if (memWrite !== r.expMemWrite) begin
            $display("MISMATCH %s memWrite got %h expected %h", names[idx], memWrite,
                     r.expMemWrite);
            errs++;
        end
        if (branchTaken !== r.expBranch) begin
            $display("MISMATCH %s branchTaken got %h expected %h", names[idx], branchTaken,
                     r.expBranch);
            errs++;
        end
        if (ecallValid !== r.expEcall) begin
            $display("MISMATCH %s ecallValid got %h expected %h", names[idx], ecallValid,
                     r.expEcall);
            errs++;
        end
        // Ecall taps only matter on the ecall row
        if (r.expEcall && ecallCode !== r.expCode) begin
            $display("MISMATCH %s ecallCode got %h expected %h", names[idx], ecallCode,
                     r.expCode);
            errs++;
        end
        if (r.expEcall && ecallA0 !== r.expA0) begin
            $display("MISMATCH %s ecallA0 got %h expected %h", names[idx], ecallA0, r.expA0);
            errs++;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int errs;
        bit released;
        // NOP while in reset
        inst        = 32'h0000_0013;
        pc          = '0;
        memReadData = '0;
        passCount   = 0;
        failCount   = 0;
        buildTable();
        waitResetRelease(released);
        if (!released) begin
            $display("Timeout: reset was not released within 10 cycles");
            $display("Some tests failed");
        end else begin
            for (int i = 0; i < rows.size(); i++) begin
                @(negedge clk);
                inst        = rows[i].inst;
                pc          = rows[i].pc;
                memReadData = rows[i].memData;
                // Settle, well before the next rising edge
                #10;
                checkRow(i, errs);
                if (errs == 0) begin
                    passCount++;
                    $display("PASS %0d %s", i, names[i]);
                end else begin
                    failCount++;
                    $display("FAIL %0d %s", i, names[i]);
                end
            end
            $display("Tests run %0d, passed %0d, failed %0d", rows.size(), passCount,
                     failCount);
            if (failCount == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/riscvDatapath_sva.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_config.svh"

module riscvDatapath_sva (
    input logic             clk,
    input logic             reset,
    input logic [`XLEN-1:0] inst,
    input logic             memRead,
    input logic             memWrite,
    input logic             branchTaken,
    input logic             ecallValid
);
    import riscvIsaPkg::*;

    // ------------------------------------------------------------
    // Memory strobes and control outputs
    // ------------------------------------------------------------
    // One memory access kind per instruction
    memExclusive: assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    // Ecall never touches memory
    ecallNoMem: assert property (@(posedge clk) disable iff (reset)
        ecallValid |-> (!memRead && !memWrite))
        else $error("memory strobe raised together with ecallValid");

    // Only branch opcodes redirect
    branchOpcode: assert property (@(posedge clk) disable iff (reset)
        branchTaken |-> (inst[6:0] == opcBranch))
        else $error("branchTaken high for a non-branch opcode");

endmodule

bind riscvDatapath riscvDatapath_sva riscvDatapath_sva_i (
    .clk         (clk),
    .reset       (reset),
    .inst        (inst),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .branchTaken (branchTaken),
    .ecallValid  (ecallValid)
);

`default_nettype wire
